//--- hdl/als_pkg.sv
// Shared definitions for the ambient-light and proximity readout path
// Widths, lux coefficients, filter threshold and packed sample types
`default_nettype none

package als_pkg;

	// --------------------
	// Widths that carry a meaning
	typedef logic [15:0] prox_t;
	typedef logic [15:0] chan_t;
	typedef logic [31:0] lux_t;
	typedef logic [31:0] bcd_t;
	// Active-low bar, one segment per bit
	typedef logic [7:0]  bar_t;

	// Raw sample from the sensor, 48 bits
	typedef struct packed {
		prox_t prox;
		chan_t ch0;
		chan_t ch1;
	} sample_t;

	// Result handed from front end to converter, 40 bits
	typedef struct packed {
		lux_t lux;
		bar_t bar;
	} reading_t;

	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		DONE
	} conv_state_t;

	// --------------------
	// Smallest proximity step treated as a glitch
	localparam prox_t PROX_JUMP_LIMIT = 16'h800;
	// All segments off
	localparam bar_t  BAR_BLANK       = 8'hFF;

	// Largest value shown on eight digits
	localparam lux_t  LUX_MAX         = 32'd99_999_999;
	localparam int    LUX_W           = 32;
	localparam int    SHIFT_CNT_W     = 5;

	// Ratio breakpoints, ch1 against ch0 scaled
	localparam lux_t  LUX_BP0 = 32'd595;
	localparam lux_t  LUX_BP1 = 32'd1015;
	localparam lux_t  LUX_BP2 = 32'd1352;
	localparam lux_t  LUX_BP3 = 32'd3053;

	// Coefficient pairs per region, lux = ch0*ca - ch1*cb
	localparam lux_t  LUX_CA0 = 32'd1682;
	localparam lux_t  LUX_CB0 = 32'd1877;
	localparam lux_t  LUX_CA1 = 32'd644;
	localparam lux_t  LUX_CB1 = 32'd132;
	localparam lux_t  LUX_CA2 = 32'd756;
	localparam lux_t  LUX_CB2 = 32'd243;
	localparam lux_t  LUX_CA3 = 32'd766;
	localparam lux_t  LUX_CB3 = 32'd25;

	// Reading buffer geometry
	localparam int    FIFO_DEPTH = 4;
	localparam int    FIFO_PTR_W = 2;

endpackage

`default_nettype wire

//--- hdl/als_frontend.sv
// Sensor front end
// Registers samples, drops proximity glitches, builds bar and lux
`timescale 1ns/1ns
`default_nettype none

module als_frontend (
	input  logic             dat_valid,
	input  logic             reset,
	input  logic             sample_strobe,
	input  als_pkg::sample_t sample,
	output als_pkg::reading_t reading,
	output logic             reading_valid
);

	import als_pkg::*;

	// Filter history and accepted proximity
	prox_t prev_prox;
	prox_t held_prox;
	prox_t prox_step;

	// Registered channel counts
	chan_t ch0_q;
	chan_t ch1_q;
	logic  strobe_q;

	// Lux datapath
	lux_t  ch0_w;
	lux_t  ch1_w;
	lux_t  coef_a;
	lux_t  coef_b;
	lux_t  pos_term;
	lux_t  neg_term;
	logic  region_hit;
	lux_t  lux_calc;

	logic [2:0] bar_code;
	bar_t       bar_calc;

	// --------------------
	// Stage 1 sample capture and jump filter

	// Distance from the previous raw proximity in either direction
	assign prox_step = (sample.prox >= prev_prox) ? (sample.prox - prev_prox)
	                                              : (prev_prox - sample.prox);

	always_ff @(posedge dat_valid) begin
		if (reset) begin
			prev_prox <= '0;
			held_prox <= '0;
			strobe_q  <= 1'b0;
		end else begin
			strobe_q <= sample_strobe;
			if (sample_strobe) begin
				// History always follows the raw input
				prev_prox <= sample.prox;
				// Big jumps leave the held value alone
				if (prox_step < PROX_JUMP_LIMIT)
					held_prox <= sample.prox;
			end
		end
	end

	// Channel capture on each strobe
	always_ff @(posedge dat_valid) begin
		if (sample_strobe) begin
			ch0_q <= sample.ch0;
			ch1_q <= sample.ch1;
		end
	end

	// --------------------
	// Bar pattern from the held proximity

	assign bar_code = held_prox[11:9];
	// Code 0 clears bit 0 and each step clears one more low bit
	assign bar_calc = (BAR_BLANK << 1) << bar_code;

	// --------------------
	// Piecewise-linear lux

	assign ch0_w = lux_t'(ch0_q);
	assign ch1_w = lux_t'(ch1_q);

	// First breakpoint above the channel ratio picks the pair
	always_comb begin
		region_hit = 1'b1;
		coef_a     = '0;
		coef_b     = '0;
		if (ch1_w < ch0_w * LUX_BP0) begin
			coef_a = LUX_CA0;
			coef_b = LUX_CB0;
		end else if (ch1_w < ch0_w * LUX_BP1) begin
			coef_a = LUX_CA1;
			coef_b = LUX_CB1;
		end else if (ch1_w < ch0_w * LUX_BP2) begin
			coef_a = LUX_CA2;
			coef_b = LUX_CB2;
		end else if (ch1_w < ch0_w * LUX_BP3) begin
			coef_a = LUX_CA3;
			coef_b = LUX_CB3;
		end else begin
			region_hit = 1'b0;
		end
	end

	assign pos_term = ch0_w * coef_a;
	assign neg_term = ch1_w * coef_b;

	// No region or negative result reads as dark
	// Top end saturates at LUX_MAX
	always_comb begin
		if (!region_hit || (neg_term > pos_term))
			lux_calc = '0;
		else if ((pos_term - neg_term) > LUX_MAX)
			lux_calc = LUX_MAX;
		else
			lux_calc = pos_term - neg_term;
	end

	// --------------------
	// Stage 2 result register and push pulse

	always_ff @(posedge dat_valid) begin
		if (reset)
			reading_valid <= 1'b0;
		else
			reading_valid <= strobe_q;
	end

	always_ff @(posedge dat_valid) begin
		if (strobe_q) begin
			reading.lux <= lux_calc;
			reading.bar <= bar_calc;
		end
	end

endmodule

`default_nettype wire

//--- hdl/reading_fifo.sv
// Reading buffer
// Four-entry circular FIFO, drops pushes when full and flags overflow
`timescale 1ns/1ns
`default_nettype none

module reading_fifo (
	input  logic              dat_valid,
	input  logic              reset,
	input  logic              push,
	input  als_pkg::reading_t din,
	input  logic              pop,
	output als_pkg::reading_t head,
	output logic              empty,
	output logic              overflow
);

	import als_pkg::*;

	reading_t mem [FIFO_DEPTH];

	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	// One extra bit so a full buffer is distinct from empty
	logic [FIFO_PTR_W:0]   count;

	logic full;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full  = (count == FIFO_DEPTH);

	// A pop at the same edge frees the slot for the push
	assign do_push = push && (!full || pop);
	assign do_pop  = pop && !empty;

	assign head = mem[rd_ptr];

	// --------------------
	// Pointers, occupancy, overflow

	always_ff @(posedge dat_valid) begin
		if (reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;

			// Simultaneous push and pop leave the count as is
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			// Sticky until reset, lost reading is not recoverable
			if (push && !do_push)
				overflow <= 1'b1;
		end
	end

	// Storage
	always_ff @(posedge dat_valid) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

endmodule

`default_nettype wire

//--- hdl/lux_bcd_converter.sv
// Lux to BCD converter
// Pops a reading, runs shift-and-add-three over 32 bits, shows digits and bar
`timescale 1ns/1ns
`default_nettype none

module lux_bcd_converter (
	input  logic              dat_valid,
	input  logic              reset,
	input  logic              empty,
	input  als_pkg::reading_t head,
	output logic              pop,
	output als_pkg::bcd_t     lux_bcd,
	output als_pkg::bar_t     bar_out,
	output logic              result_done
);

	import als_pkg::*;

	conv_state_t state;

	// Working registers for one conversion
	lux_t bin_sr;
	bcd_t bcd_acc;
	bcd_t bcd_adj;
	bar_t bar_hold;

	logic [SHIFT_CNT_W-1:0] bit_cnt;
	logic                   last_bit;

	// Add three to every digit of five or more
	function automatic bcd_t add3_digits(input bcd_t value);
		bcd_t result;
		result = value;
		for (int d = 0; d < 8; d++) begin
			if (value[d*4 +: 4] >= 4'd5)
				result[d*4 +: 4] = value[d*4 +: 4] + 4'd3;
		end
		return result;
	endfunction

	// Take the head as soon as one is waiting
	assign pop = (state == IDLE) && !empty;

	assign bcd_adj  = add3_digits(bcd_acc);
	assign last_bit = (bit_cnt == SHIFT_CNT_W'(LUX_W - 1));

	// --------------------
	// Control FSM and outputs

	always_ff @(posedge dat_valid) begin
		if (reset) begin
			state       <= IDLE;
			bit_cnt     <= '0;
			result_done <= 1'b0;
			lux_bcd     <= '0;
			bar_out     <= BAR_BLANK;
		end else begin
			result_done <= 1'b0;
			case (state)
				IDLE: begin
					bit_cnt <= '0;
					if (pop)
						state <= SHIFT;
				end
				SHIFT: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (last_bit)
						state <= DONE;
				end
				DONE: begin
					// Digits and bar change together with the pulse
					lux_bcd     <= bcd_acc;
					bar_out     <= bar_hold;
					result_done <= 1'b1;
					state       <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// --------------------
	// Datapath, MSB of lux enters first

	always_ff @(posedge dat_valid) begin
		if (pop) begin
			bin_sr   <= head.lux;
			bcd_acc  <= '0;
			bar_hold <= head.bar;
		end else if (state == SHIFT) begin
			bcd_acc <= {bcd_adj[30:0], bin_sr[LUX_W-1]};
			bin_sr  <= bin_sr << 1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/als_decoder_top.sv
// Readout top level
// Front end feeds the reading FIFO, converter drains it to BCD
`timescale 1ns/1ns
`default_nettype none

module als_decoder_top (
	input  logic             dat_valid,
	input  logic             reset,
	input  logic             sample_strobe,
	input  als_pkg::sample_t sample,
	output als_pkg::bcd_t    lux_bcd,
	output als_pkg::bar_t    bar_out,
	output logic             result_done,
	output logic             overflow
);

	import als_pkg::*;

	// Front end to FIFO
	reading_t reading;
	logic     reading_valid;

	// FIFO to converter
	reading_t head;
	logic     empty;
	logic     pop;

	als_frontend i_als_frontend (
		.dat_valid     (dat_valid),
		.reset         (reset),
		.sample_strobe (sample_strobe),
		.sample        (sample),
		.reading       (reading),
		.reading_valid (reading_valid)
	);

	// Push straight from the front end pulse
	reading_fifo i_reading_fifo (
		.dat_valid (dat_valid),
		.reset     (reset),
		.push      (reading_valid),
		.din       (reading),
		.pop       (pop),
		.head      (head),
		.empty     (empty),
		.overflow  (overflow)
	);

	lux_bcd_converter i_lux_bcd_converter (
		.dat_valid   (dat_valid),
		.reset       (reset),
		.empty       (empty),
		.head        (head),
		.pop         (pop),
		.lux_bcd     (lux_bcd),
		.bar_out     (bar_out),
		.result_done (result_done)
	);

endmodule

`default_nettype wire

//--- testbench/als_decoder_properties.sv
// Concurrent checks on the reading FIFO and the BCD converter
// Bound into both blocks, unused inputs tied off per target
`timescale 1ns/1ns
`default_nettype none

module als_decoder_properties (
	input logic dat_valid,
	input logic reset,
	input logic result_done,
	input logic pop,
	input logic empty,
	input logic overflow
);

	// Done is a single-cycle pulse
	done_one_cycle: assert property (@(posedge dat_valid) disable iff (reset)
		result_done |=> !result_done)
		else $error("result_done held high for more than one cycle");

	// Converter only pops a waiting reading
	no_pop_when_empty: assert property (@(posedge dat_valid) disable iff (reset)
		pop |-> !empty)
		else $error("pop raised while the FIFO is empty");

	// Sticky flag, only reset clears it
	overflow_sticky: assert property (@(posedge dat_valid)
		$fell(overflow) |-> $past(reset))
		else $error("overflow fell without reset");

endmodule

bind lux_bcd_converter als_decoder_properties i_conv_properties (
	.dat_valid   (dat_valid),
	.reset       (reset),
	.result_done (result_done),
	.pop         (pop),
	.empty       (empty),
	.overflow    (1'b0)
);

bind reading_fifo als_decoder_properties i_fifo_properties (
	.dat_valid   (dat_valid),
	.reset       (reset),
	.result_done (1'b0),
	.pop         (pop),
	.empty       (empty),
	.overflow    (overflow)
);

`default_nettype wire

//--- testbench/als_decoder_tb.sv
// Testbench for the ambient-light readout path
// Directed tests against a reference model of filter, bar, lux and BCD digits
`timescale 1ns/1ns
`default_nettype none

module als_decoder_tb;

	import als_pkg::*;

	// DUT ports
	logic    dat_valid;
	logic    reset;
	logic    sample_strobe;
	sample_t sample;
	bcd_t    lux_bcd;
	bar_t    bar_out;
	logic    result_done;
	logic    overflow;

	// Model state, mirrors the front end filter
	prox_t    model_prev;
	prox_t    model_held;
	reading_t expected_q [$];
	integer   seed;

	als_decoder_top i_als_decoder_top (
		.dat_valid     (dat_valid),
		.reset         (reset),
		.sample_strobe (sample_strobe),
		.sample        (sample),
		.lux_bcd       (lux_bcd),
		.bar_out       (bar_out),
		.result_done   (result_done),
		.overflow      (overflow)
	);

	// 100 ns period
	always #50 dat_valid = ~dat_valid;

	// --------------------
	// Reference model

	// First breakpoint that ch1 stays under picks the pair
	function automatic lux_t model_lux(input chan_t c0, input chan_t c1);
		longint bp [4];
		longint ca [4];
		longint cb [4];
		longint diff;
		int     region;
		bp = '{LUX_BP0, LUX_BP1, LUX_BP2, LUX_BP3};
		ca = '{LUX_CA0, LUX_CA1, LUX_CA2, LUX_CA3};
		cb = '{LUX_CB0, LUX_CB1, LUX_CB2, LUX_CB3};
		region = -1;
		// Walk down so the lowest matching region wins
		for (int i = 3; i >= 0; i--) begin
			if (longint'(c1) < longint'(c0) * bp[i])
				region = i;
		end
		if (region < 0)
			return '0;
		diff = longint'(c0) * ca[region] - longint'(c1) * cb[region];
		if (diff < 0)
			return '0;
		if (diff > longint'(LUX_MAX))
			return LUX_MAX;
		return lux_t'(diff);
	endfunction

	// Segment i is on (low) when i is at most the code
	function automatic bar_t model_bar(input prox_t held);
		bar_t bar;
		int   code;
		code = int'(held[11:9]);
		for (int i = 0; i < 8; i++)
			bar[i] = (i > code);
		return bar;
	endfunction

	// Decimal digits by division, least significant digit first
	function automatic bcd_t model_bcd(input lux_t value);
		bcd_t digits;
		lux_t rest;
		digits = '0;
		rest   = value;
		for (int d = 0; d < 8; d++) begin
			digits[d*4 +: 4] = 4'(rest % 10);
			rest = rest / 10;
		end
		return digits;
	endfunction

	task automatic model_sample(input sample_t s, output reading_t r);
		int step;
		step = int'(s.prox) - int'(model_prev);
		if (step < 0)
			step = -step;
		if (step < int'(PROX_JUMP_LIMIT))
			model_held = s.prox;
		model_prev = s.prox;
		r.lux = model_lux(s.ch0, s.ch1);
		r.bar = model_bar(model_held);
	endtask

	// --------------------
	// Checking and waiting

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
	                           input logic [31:0] expected);
		if (actual !== expected) begin
			$display("** Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
			stop_run();
		end
	endtask

	// Returns at the falling edge where result_done is seen high
	task automatic wait_result();
		int cycles;
		cycles = 0;
		@(negedge dat_valid);
		while (!result_done) begin
			if (cycles >= 200) begin
				$display("No result arrived within 200 cycles");
				stop_run();
			end
			cycles++;
			@(negedge dat_valid);
		end
	endtask

	task automatic expect_no_result(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge dat_valid);
			if (result_done) begin
				$display("A result arrived although the reading should have been dropped");
				stop_run();
			end
		end
	endtask

	// Oldest expected reading against the displayed result
	task automatic check_result();
		reading_t exp;
		if (expected_q.size() == 0) begin
			$display("A result arrived with no reading expected");
			stop_run();
		end
		exp = expected_q.pop_front();
		check_value("lux_bcd", lux_bcd, model_bcd(exp.lux));
		check_value("bar_out", 32'(bar_out), 32'(exp.bar));
	endtask

	// --------------------
	// Stimulus helpers

	// Strobe stays high until end_strobe, so back-to-back calls form a burst
	task automatic strobe_sample(input sample_t s, input bit kept);
		reading_t exp;
		@(negedge dat_valid);
		sample        = s;
		sample_strobe = 1'b1;
		model_sample(s, exp);
		if (kept)
			expected_q.push_back(exp);
	endtask

	task automatic end_strobe();
		@(negedge dat_valid);
		sample_strobe = 1'b0;
	endtask

	task automatic send_and_check(input sample_t s);
		strobe_sample(s, 1'b1);
		end_strobe();
		wait_result();
		check_result();
	endtask

	// --------------------
	// Directed tests

	task automatic test_reset_state();
		@(negedge dat_valid);
		check_value("lux_bcd", lux_bcd, 32'h0);
		check_value("bar_out", 32'(bar_out), 32'hFF);
		check_value("result_done", 32'(result_done), 32'h0);
		check_value("overflow", 32'(overflow), 32'h0);
	endtask

	task automatic test_lux_regions();
		sample_t s;
		s.prox = '0;
		// Region 0, positive result
		s.ch0 = 16'd100;
		s.ch1 = 16'd50;
		send_and_check(s);
		// Regions 1 to 3 all come out negative
		s.ch0 = 16'd1;
		s.ch1 = 16'd600;
		send_and_check(s);
		s.ch1 = 16'd1100;
		send_and_check(s);
		s.ch1 = 16'd2000;
		send_and_check(s);
		// Above the last breakpoint
		s.ch0 = 16'd2;
		s.ch1 = 16'd7000;
		send_and_check(s);
		// Full scale ch0 saturates
		s.ch0 = 16'hFFFF;
		s.ch1 = 16'd0;
		send_and_check(s);
		check_value("lux_bcd", lux_bcd, 32'h9999_9999);
	endtask

	task automatic test_prox_filter();
		sample_t s;
		prox_t   steps   [11];
		bar_t    bar_lit [11];
		// Rising codes 1..7, a big jump down, recovery, an exact-limit step
		steps   = '{16'h0200, 16'h0400, 16'h0600, 16'h0800, 16'h0A00, 16'h0C00,
		            16'h0E00, 16'h0200, 16'h0300, 16'h0B00, 16'h0A00};
		bar_lit = '{8'hFC, 8'hF8, 8'hF0, 8'hE0, 8'hC0, 8'h80,
		            8'h00, 8'h00, 8'hFC, 8'hFC, 8'hC0};
		s.ch0 = 16'd10;
		s.ch1 = 16'd5;
		for (int i = 0; i < 11; i++) begin
			s.prox = steps[i];
			send_and_check(s);
			check_value("bar_out", 32'(bar_out), 32'(bar_lit[i]));
		end
	endtask

	task automatic test_burst_overflow();
		sample_t s;
		check_value("overflow", 32'(overflow), 32'h0);
		// Converter takes the first, FIFO holds four, the sixth is lost
		for (int i = 0; i < 6; i++) begin
			s.prox = 16'h0A00 + 16'(i * 16'h40);
			s.ch0  = 16'(1000 + i * 37);
			s.ch1  = 16'(200 * i);
			strobe_sample(s, i < 5);
		end
		end_strobe();
		for (int i = 0; i < 5; i++) begin
			wait_result();
			check_result();
		end
		check_value("overflow", 32'(overflow), 32'h1);
		expect_no_result(80);
		check_value("overflow", 32'(overflow), 32'h1);
	endtask

	task automatic test_random_samples();
		sample_t     s;
		logic [31:0] rnd;
		for (int i = 0; i < 20; i++) begin
			rnd    = $random(seed);
			s.prox = {4'h0, rnd[11:0]};
			s.ch0  = rnd[31:16];
			rnd    = $random(seed);
			// Varying shift spreads the channel ratio
			s.ch1  = rnd[15:0] >> rnd[19:16];
			send_and_check(s);
		end
		check_value("overflow", 32'(overflow), 32'h1);
	endtask

	// --------------------
	// Main sequence

	initial begin
		dat_valid     = 1'b0;
		reset         = 1'b1;
		sample_strobe = 1'b0;
		sample        = '0;
		model_prev    = '0;
		model_held    = '0;
		seed          = 32'h09f7_eee6;

		repeat (8) @(negedge dat_valid);
		reset = 1'b0;

		test_reset_state();
		test_lux_regions();
		test_prox_filter();
		test_burst_overflow();
		test_random_samples();

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
hdl/als_pkg.sv
hdl/als_frontend.sv
hdl/reading_fifo.sv
hdl/lux_bcd_converter.sv
hdl/als_decoder_top.sv
testbench/als_decoder_properties.sv
testbench/als_decoder_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module als_decoder_tb -o als_decoder_sim; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/als_decoder_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "PASS: all tests"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
